// File: files.f
+incdir+verif
hdl/decode_pkg.sv
hdl/op_decoder.sv
hdl/imm_gen.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
verif/decode_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/op_decoder.sv
  - hdl/imm_gen.sv
  - hdl/hazard_unit.sv
  - hdl/decode_stage.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/decode_tb.sv

// File: verif/decode_ref.svh
// Reference model for the decode stage testbench
// Register file contents, operation, format and immediate rules,
// and the expected issue record of a fetched word

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Register contents follow the index, x0 reads zero
function automatic logic [XLEN-1:0] reg_value(input logic [REG_ADDR_W-1:0] idx);
    if (idx == '0) begin
        return '0;
    end
    return 32'h9e37_79b9 * XLEN'(idx);
endfunction

function automatic op_e ref_alu(input logic [2:0] f3, input logic [6:0] f7,
                                input logic reg_form);
    logic shift;
    logic alt;
    shift = (f3 == 3'b001) || (f3 == 3'b101);
    alt   = (f7 == 7'h20);
    // Register forms and shifts only accept funct7 zero or the alternate bit
    if ((reg_form || shift) && (f7 != 7'h00)
            && !(alt && ((f3 == 3'b101) || (reg_form && f3 == 3'b000)))) begin
        return INVALID;
    end
    case (f3)
        3'b000:  return (reg_form && alt) ? SUB : ADD;
        3'b001:  return SLL;
        3'b010:  return SLT;
        3'b011:  return SLTU;
        3'b100:  return XOR;
        3'b101:  return alt ? SRA : SRL;
        3'b110:  return OR;
        default: return AND;
    endcase
endfunction

function automatic op_e ref_system(input logic [31:0] w);
    case (w[14:12])
        3'b001: return CSRRW;
        3'b010: return CSRRS;
        3'b011: return CSRRC;
        3'b101: return CSRRWI;
        3'b110: return CSRRSI;
        3'b111: return CSRRCI;
        default: ;
    endcase
    // Privileged words match exactly
    if (w == 32'h0000_0073) return ECALL;
    if (w == 32'h0010_0073) return EBREAK;
    if (w == 32'h1020_0073) return SRET;
    if (w == 32'h3020_0073) return MRET;
    if (w == 32'h1050_0073) return WFI;
    return INVALID;
endfunction

function automatic op_e ref_op(input logic [31:0] w);
    op_e         branch_ops [8];
    op_e         load_ops [8];
    op_e         store_ops [8];
    logic [2:0]  f3;
    f3 = w[14:12];
    branch_ops = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    load_ops   = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    store_ops  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    case (w[6:0])
        OPC_LUI:      return LUI;
        OPC_AUIPC:    return ADD;
        OPC_JAL:      return JAL;
        OPC_JALR:     return JALR;
        OPC_BRANCH:   return branch_ops[f3];
        OPC_LOAD:     return load_ops[f3];
        OPC_STORE:    return store_ops[f3];
        OPC_OP_IMM:   return ref_alu(f3, w[31:25], 1'b0);
        OPC_OP:       return ref_alu(f3, w[31:25], 1'b1);
        OPC_MISC_MEM: return (f3 == 3'b000) ? NOP : INVALID;
        OPC_SYSTEM:   return ref_system(w);
        default:      return INVALID;
    endcase
endfunction

function automatic format_e ref_format(input logic [31:0] w);
    case (w[6:0])
        OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_FMT;
        OPC_STORE:                      return S_FMT;
        OPC_BRANCH:                     return B_FMT;
        OPC_LUI, OPC_AUIPC:             return U_FMT;
        OPC_JAL:                        return J_FMT;
        default:                        return R_FMT;
    endcase
endfunction

function automatic logic [XLEN-1:0] ref_imm(input logic [31:0] w, input format_e fmt);
    case (fmt)
        I_FMT:   return {{20{w[31]}}, w[31:20]};
        S_FMT:   return {{20{w[31]}}, w[31:25], w[11:7]};
        B_FMT:   return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        U_FMT:   return {w[31:12], 12'h000};
        J_FMT:   return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default: return '0;
    endcase
endfunction

// Expected issue record one cycle after the word is accepted
function automatic issue_t ref_decode(input fetch_t f, input logic [XLEN-1:0] rs1_val,
                                      input logic [XLEN-1:0] rs2_val);
    issue_t          r;
    format_e         fmt;
    logic [XLEN-1:0] imm;
    fmt = ref_format(f.instr);
    imm = ref_imm(f.instr, fmt);
    r = '0;
    r.op             = ref_op(f.instr);
    r.pc             = f.pc;
    r.instr          = f.instr;
    r.tag            = f.tag;
    r.illegal        = (r.op == INVALID);
    r.first_operand  = (fmt == U_FMT || fmt == J_FMT) ? f.pc : rs1_val;
    r.second_operand = (fmt == R_FMT || fmt == B_FMT) ? rs2_val : imm;
    r.third_operand  = (fmt == S_FMT) ? rs2_val : imm;
    return r;
endfunction

`endif

// File: verif/decode_tb.sv
// Testbench for the RV32I decode stage
// Clock, reset, random and directed stimulus, the comparing process,
// compare tasks and the watchdog

`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    `include "decode_ref.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 67148;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 40;
    localparam int NUM_WORDS    = NUM_RANDOM + NUM_DIRECTED;

    typedef struct packed {
        issue_t                issue;
        logic [REG_ADDR_W-1:0] rd;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  stall_i;
    fetch_t                fetch_i;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_lock;
    logic                  hazard;
    issue_t                issue;

    // Model state of the issue register and the lock queue
    expect_t               pending [$];
    issue_t                held_issue;
    logic [REG_ADDR_W-1:0] lock_rd;
    logic                  lock_store;
    logic [REG_ADDR_W-1:0] rd_expect;
    logic [TAG_W-1:0]      next_tag;

    decode_stage #(
        .TAG_W (TAG_W)
    ) decode_stage_i (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .fetch_i    (fetch_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1_addr),
        .rs2_o      (rs2_addr),
        .rd_o       (rd_lock),
        .hazard_o   (hazard),
        .issue_o    (issue)
    );

    // Register file answers in the same cycle
    assign rs1_data = reg_value(rs1_addr);
    assign rs2_data = reg_value(rs2_addr);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_issue(input string name, input issue_t got, input issue_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
                             input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic fetch_t make_fetch(input logic [31:0] w);
        fetch_t f;
        f.instr  = w;
        f.pc     = $urandom & 32'hffff_fffc;
        f.tag    = next_tag;
        next_tag = next_tag + 1'b1;
        return f;
    endfunction

    // Covers every opcode group plus unknown opcodes
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 3))
            0:       w[31:25] = 7'h00;
            1:       w[31:25] = 7'h20;
            default: ;
        endcase
        case ($urandom_range(0, 13))
            0:  w[6:0] = OPC_LUI;
            1:  w[6:0] = OPC_AUIPC;
            2:  w[6:0] = OPC_JAL;
            3:  w[6:0] = OPC_JALR;
            4:  w[6:0] = OPC_BRANCH;
            5:  w[6:0] = OPC_LOAD;
            6:  w[6:0] = OPC_STORE;
            7:  w[6:0] = OPC_OP_IMM;
            8:  w[6:0] = OPC_MISC_MEM;
            9:  w[6:0] = OPC_SYSTEM;
            10: w[6:0] = 7'($urandom);
            11: begin
                case ($urandom_range(0, 4))
                    0:       w = 32'h0000_0073;
                    1:       w = 32'h0010_0073;
                    2:       w = 32'h1020_0073;
                    3:       w = 32'h3020_0073;
                    default: w = 32'h1050_0073;
                endcase
            end
            default: w[6:0] = OPC_OP;
        endcase
        return w;
    endfunction

    // True when the word would collide with the locked register or store
    function automatic logic conflicts(input logic [31:0] w);
        logic reads;
        reads = (lock_rd != '0) && ((w[19:15] == lock_rd) || (w[24:20] == lock_rd));
        return reads || (lock_store && (w[6:0] == OPC_LOAD));
    endfunction

    task automatic next_fetch(output fetch_t f);
        logic [31:0] w;
        w = random_word();
        while (conflicts(w)) begin
            w = random_word();
        end
        f = make_fetch(w);
    endtask

    // One cycle of input, with the expected state after the next edge
    task automatic drive_cycle(input fetch_t f, input logic stall, input logic exp_hazard);
        expect_t e;
        @(posedge clk);
        #2;
        fetch_i = f;
        stall_i = stall;
        #1;
        check_flag("hazard_o", hazard, exp_hazard);
        check_reg("rs1_o", rs1_addr, f.instr.r_fields.rs1);
        check_reg("rs2_o", rs2_addr, f.instr.r_fields.rs2);
        if (exp_hazard) begin
            held_issue     = '0;
            held_issue.op  = NOP;
            held_issue.tag = f.tag;
        end else if (!stall) begin
            held_issue = ref_decode(f, reg_value(f.instr.r_fields.rs1),
                                    reg_value(f.instr.r_fields.rs2));
        end
        if (!stall) begin
            rd_expect  = lock_rd;
            lock_rd    = exp_hazard ? '0 : f.instr.r_fields.rd;
            lock_store = !exp_hazard && (f.instr.r_fields.opcode == OPC_STORE);
        end
        e.issue = held_issue;
        e.rd    = rd_expect;
        pending.push_back(e);
    endtask

    // A hazard is followed by the re-decode of the same held word
    task automatic send_word(input logic [31:0] w, input logic exp_hazard);
        fetch_t f;
        f = make_fetch(w);
        drive_cycle(f, 1'b0, exp_hazard);
        if (exp_hazard) begin
            drive_cycle(f, 1'b0, 1'b0);
        end
    endtask

    task automatic run_random(input int count);
        fetch_t f;
        repeat (count) begin
            next_fetch(f);
            drive_cycle(f, 1'b0, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////////////////////////

    initial begin : compare_results
        expect_t e;
        forever begin
            @(posedge clk);
            #1;
            if (pending.size() > 0) begin
                e = pending.pop_front();
                check_issue("issue_o", issue, e.issue);
                check_reg("rd_o", rd_lock, e.rd);
            end
        end
    end

    initial begin : watchdog
        #((NUM_WORDS + RESET_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the allowed time");
        stop_with_failure();
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : run_tests
        fetch_t f;
        void'($urandom(SEED));
        reset      = 1'b1;
        stall_i    = 1'b1;
        fetch_i    = '0;
        lock_rd    = '0;
        lock_store = 1'b0;
        rd_expect  = '0;
        next_tag   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        // Reset state, no new word accepted yet
        @(posedge clk);
        #1;
        held_issue    = '0;
        held_issue.op = NOP;
        check_issue("issue_o", issue, held_issue);
        check_flag("hazard_o", hazard, 1'b0);
        check_reg("rd_o", rd_lock, '0);

        run_random(NUM_RANDOM / 2);

        // Clear the lock, then read after write through rs1 and rs2
        send_word(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, OPC_OP), 1'b0);
        send_word(encode(7'h00, 5'd2, 5'd1, 3'b000, 5'd9, OPC_OP), 1'b0);
        send_word(encode(7'h20, 5'd5, 5'd9, 3'b000, 5'd4, OPC_OP), 1'b1);
        send_word(encode(7'h01, 5'd4, 5'd6, 3'b010, 5'd3, OPC_STORE), 1'b1);

        // Load right behind a store
        send_word(encode(7'h00, 5'd8, 5'd10, 3'b010, 5'd8, OPC_LOAD), 1'b1);

        // Writes to x0 lock nothing
        send_word(encode(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        send_word(encode(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, OPC_OP), 1'b0);
        send_word(encode(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        send_word(encode(7'h3f, 5'd0, 5'd0, 3'b000, 5'd17, OPC_BRANCH), 1'b0);
        send_word(encode(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        send_word(encode(7'h00, 5'd0, 5'd0, 3'b010, 5'd0, OPC_STORE), 1'b0);
        send_word(encode(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        send_word(encode(7'h00, 5'd1, 5'd0, 3'b000, 5'd6, OPC_OP_IMM), 1'b0);

        // Stall holds issue_o and rd_o, then the held word goes out
        next_fetch(f);
        drive_cycle(f, 1'b0, 1'b0);
        next_fetch(f);
        repeat (3) drive_cycle(f, 1'b1, 1'b0);
        drive_cycle(f, 1'b0, 1'b0);

        run_random(NUM_RANDOM / 2);

        // Let the last word reach the comparing process
        @(posedge clk);
        #2;
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: hdl/decode_stage.sv
// Instruction decode stage of the five-stage RV32I core
// Operand selection and the issue register with bubble insertion

`timescale 1ns/1ps

module decode_stage #(
    parameter int TAG_W = decode_pkg::TAG_W
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  decode_pkg::fetch_t                fetch_i,
    input  logic [decode_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [decode_pkg::XLEN-1:0]       rs2_data_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                              hazard_o,
    output decode_pkg::issue_t                issue_o
);
    import decode_pkg::*;

    instr_u           active_instr;
    op_e              op;
    format_e          fmt;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  first_operand;
    logic [XLEN-1:0]  second_operand;
    logic [XLEN-1:0]  third_operand;
    logic [TAG_W-1:0] fetch_tag;
    issue_t           issue_d;
    issue_t           bubble;

    hazard_unit u_hazard_unit (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .instr_i        (fetch_i.instr),
        .fmt_i          (fmt),
        .active_instr_o (active_instr),
        .hazard_o       (hazard_o),
        .rd_o           (rd_o)
    );

    op_decoder u_op_decoder (
        .instr_i (active_instr),
        .op_o    (op),
        .fmt_o   (fmt)
    );

    imm_gen u_imm_gen (
        .instr_i (active_instr),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    // Register file read addresses
    assign rs1_o = active_instr.r_fields.rs1;
    assign rs2_o = active_instr.r_fields.rs2;

    assign fetch_tag = fetch_i.tag;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (fmt)
            U_FMT, J_FMT: begin
                first_operand  = fetch_i.pc;
                second_operand = imm;
                third_operand  = imm;
            end
            R_FMT, B_FMT: begin
                first_operand  = rs1_data_i;
                second_operand = rs2_data_i;
                third_operand  = imm;
            end
            // Store data rides in the third operand
            S_FMT: begin
                first_operand  = rs1_data_i;
                second_operand = imm;
                third_operand  = rs2_data_i;
            end
            default: begin
                first_operand  = rs1_data_i;
                second_operand = imm;
                third_operand  = imm;
            end
        endcase
    end

    always_comb begin
        issue_d.op             = op;
        issue_d.first_operand  = first_operand;
        issue_d.second_operand = second_operand;
        issue_d.third_operand  = third_operand;
        issue_d.pc             = fetch_i.pc;
        issue_d.instr          = active_instr;
        issue_d.tag            = fetch_tag;
        issue_d.illegal        = (op == INVALID);
    end

    // NOP bubble keeps the tag of the word being held
    always_comb begin
        bubble     = '0;
        bubble.op  = NOP;
        bubble.tag = fetch_tag;
    end

    ////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////

    // Bubble wins over stall
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o    <= '0;
            issue_o.op <= NOP;
        end else if (hazard_o) begin
            issue_o <= bubble;
        end else if (!stall_i) begin
            issue_o <= issue_d;
        end
    end

endmodule

// File: hdl/hazard_unit.sv
// Hazard unit of the decode stage
// Re-decode hold register, register lock queue and hazard detection

`timescale 1ns/1ps

module hazard_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall_i,
    input  decode_pkg::instr_u                instr_i,
    input  decode_pkg::format_e               fmt_i,
    output decode_pkg::instr_u                active_instr_o,
    output logic                              hazard_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o
);
    import decode_pkg::*;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  store;
    } lock_t;

    instr_u last_instr;
    logic   last_hazard;
    lock_t  lock_d;
    lock_t  lock_q;
    logic   use_rs1;
    logic   use_rs2;
    logic   hazard_rs1;
    logic   hazard_rs2;
    logic   hazard_mem;

    ////////////////////////////////////////////////////////////
    // Re-decode after a hazard
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= active_instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
        end
    end

    assign active_instr_o = last_hazard ? last_instr : instr_i;

    ////////////////////////////////////////////////////////////
    // Register lock queue
    ////////////////////////////////////////////////////////////

    // A bubble locks nothing
    assign lock_d.rd    = hazard_o ? '0 : active_instr_o.r_fields.rd;
    assign lock_d.store = !hazard_o && (active_instr_o.r_fields.opcode == OPC_STORE);

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q <= '0;
            rd_o   <= '0;
        end else if (!stall_i) begin
            lock_q <= lock_d;
            rd_o   <= lock_q.rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    // CSR immediate forms decode as R and so count as reading rs1
    assign use_rs1 = (fmt_i == R_FMT) || (fmt_i == B_FMT) || (fmt_i == S_FMT)
                  || (fmt_i == I_FMT);
    assign use_rs2 = (fmt_i == R_FMT) || (fmt_i == B_FMT) || (fmt_i == S_FMT);

    assign hazard_rs1 = use_rs1 && (active_instr_o.r_fields.rs1 != '0)
                     && (active_instr_o.r_fields.rs1 == lock_q.rd);
    assign hazard_rs2 = use_rs2 && (active_instr_o.r_fields.rs2 != '0)
                     && (active_instr_o.r_fields.rs2 == lock_q.rd);
    assign hazard_mem = lock_q.store && (active_instr_o.r_fields.opcode == OPC_LOAD);

    assign hazard_o = hazard_rs1 || hazard_rs2 || hazard_mem;

endmodule

// File: hdl/imm_gen.sv
// Immediate generator
// Sign-extended I, S, B, U and J immediates from the instruction union

`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::instr_u          instr_i,
    input  decode_pkg::format_e         fmt_i,
    output logic [decode_pkg::XLEN-1:0] imm_o
);
    import decode_pkg::*;

    always_comb begin
        case (fmt_i)
            I_FMT: imm_o = {{20{instr_i.i_fields.imm_11_0[11]}},
                            instr_i.i_fields.imm_11_0};
            S_FMT: imm_o = {{20{instr_i.s_fields.imm_11_5[6]}},
                            instr_i.s_fields.imm_11_5,
                            instr_i.s_fields.imm_4_0};
            // Branch offsets are even, bit 0 is implied
            B_FMT: imm_o = {{19{instr_i.b_fields.imm_12}},
                            instr_i.b_fields.imm_12,
                            instr_i.b_fields.imm_11,
                            instr_i.b_fields.imm_10_5,
                            instr_i.b_fields.imm_4_1,
                            1'b0};
            U_FMT: imm_o = {instr_i.u_fields.imm_31_12, 12'b0};
            J_FMT: imm_o = {{11{instr_i.j_fields.imm_20}},
                            instr_i.j_fields.imm_20,
                            instr_i.j_fields.imm_19_12,
                            instr_i.j_fields.imm_11,
                            instr_i.j_fields.imm_10_1,
                            1'b0};
            // R format carries no immediate
            default: imm_o = '0;
        endcase
    end

endmodule

// File: hdl/op_decoder.sv
// Operation and format decoder for RV32I
// One sub-decoder per major opcode, selected by the opcode

`timescale 1ns/1ps

module op_decoder (
    input  decode_pkg::instr_u  instr_i,
    output decode_pkg::op_e     op_o,
    output decode_pkg::format_e fmt_o
);
    import decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    op_e op_branch;
    op_e op_load;
    op_e op_store;
    op_e op_op_imm;
    op_e op_op;
    op_e op_misc_mem;
    op_e op_system;

    assign opcode = instr_i.r_fields.opcode;
    assign funct3 = instr_i.r_fields.funct3;
    assign funct7 = instr_i.r_fields.funct7;

    ////////////////////////////////////////////////////////////
    // Sub-decoders
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates still check funct7, the rest ignore it
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????000: op_op_imm = ADD;
            10'b0000000001: op_op_imm = SLL;
            10'b???????010: op_op_imm = SLT;
            10'b???????011: op_op_imm = SLTU;
            10'b???????100: op_op_imm = XOR;
            10'b0000000101: op_op_imm = SRL;
            10'b0100000101: op_op_imm = SRA;
            10'b???????110: op_op_imm = OR;
            10'b???????111: op_op_imm = AND;
            default:        op_op_imm = INVALID;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000000: op_op = ADD;
            10'b0100000000: op_op = SUB;
            10'b0000000001: op_op = SLL;
            10'b0000000010: op_op = SLT;
            10'b0000000011: op_op = SLTU;
            10'b0000000100: op_op = XOR;
            10'b0000000101: op_op = SRL;
            10'b0100000101: op_op = SRA;
            10'b0000000110: op_op = OR;
            10'b0000000111: op_op = AND;
            default:        op_op = INVALID;
        endcase
    end

    // FENCE goes down the pipe as a NOP
    assign op_misc_mem = (funct3 == 3'b000) ? NOP : INVALID;

    // Privileged forms need exact encodings, CSR forms only funct3
    always_comb begin
        case (instr_i[31:7]) inside
            25'b0000000000000000000000000: op_system = ECALL;
            25'b0000000000010000000000000: op_system = EBREAK;
            25'b0001000000100000000000000: op_system = SRET;
            25'b0011000000100000000000000: op_system = MRET;
            25'b0001000001010000000000000: op_system = WFI;
            25'b?????????????????001?????: op_system = CSRRW;
            25'b?????????????????010?????: op_system = CSRRS;
            25'b?????????????????011?????: op_system = CSRRC;
            25'b?????????????????101?????: op_system = CSRRWI;
            25'b?????????????????110?????: op_system = CSRRSI;
            25'b?????????????????111?????: op_system = CSRRCI;
            default:                       op_system = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Opcode select and format
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      op_o = LUI;
            OPC_AUIPC:    op_o = ADD;
            OPC_JAL:      op_o = JAL;
            OPC_JALR:     op_o = JALR;
            OPC_BRANCH:   op_o = op_branch;
            OPC_LOAD:     op_o = op_load;
            OPC_STORE:    op_o = op_store;
            OPC_OP_IMM:   op_o = op_op_imm;
            OPC_OP:       op_o = op_op;
            OPC_MISC_MEM: op_o = op_misc_mem;
            OPC_SYSTEM:   op_o = op_system;
            default:      op_o = INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt_o = I_FMT;
            OPC_STORE:                      fmt_o = S_FMT;
            OPC_BRANCH:                     fmt_o = B_FMT;
            OPC_LUI, OPC_AUIPC:             fmt_o = U_FMT;
            OPC_JAL:                        fmt_o = J_FMT;
            default:                        fmt_o = R_FMT;
        endcase
    end

endmodule

// File: hdl/decode_pkg.sv
// Shared types for the RV32I decode stage
// Operation, format and opcode enums, the instruction word union
// and the stage input and output structs

package decode_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;
    parameter int TAG_W      = 3;

    typedef enum logic [5:0] {
        LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LB, LH, LW, LBU, LHU, SB, SH, SW,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        NOP, INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_FMT, I_FMT, S_FMT, B_FMT, U_FMT, J_FMT
    } format_e;

    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // One view of the instruction word per format
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        opcode_e               opcode;
    } s_fields_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_fields_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } u_fields_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } j_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        s_fields_t s_fields;
        b_fields_t b_fields;
        u_fields_t u_fields;
        j_fields_t j_fields;
    } instr_u;

    ////////////////////////////////////////////////////////////
    // Stage boundary
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        instr_u             instr;
        logic [XLEN-1:0]    pc;
        logic [TAG_W-1:0]   tag;
    } fetch_t;

    typedef struct packed {
        op_e                op;
        logic [XLEN-1:0]    first_operand;
        logic [XLEN-1:0]    second_operand;
        logic [XLEN-1:0]    third_operand;
        logic [XLEN-1:0]    pc;
        instr_u             instr;
        logic [TAG_W-1:0]   tag;
        logic               illegal;
    } issue_t;

endpackage
